//--- hdl/msi_macros.svh
// Widths and counts are fixed here because the APB register map depends on them; MSI_DATA_W must be 32 or 64
`ifndef MSI_MACROS_SVH
`define MSI_MACROS_SVH

// ------------------------------
// Generator widths
// ------------------------------
`define MSI_NUM_IRQ     4
`define MSI_ADDR_W      40
// 32 or 64 only
`define MSI_DATA_W      32
`define MSI_STRB_W      ((`MSI_DATA_W + 7) / 8)
`define MSI_DEVID_W     16
`define MSI_EVTID_W     16
// Strobe bits covering the event ID bytes
`define MSI_EVT_STRB_W  ((`MSI_EVTID_W + 7) / 8)
`define MSI_THR_W       16

// ------------------------------
// APB register map
// ------------------------------
`define MSI_APB_AW      8
`define MSI_REG_CTRL    8'h00
`define MSI_REG_THR     8'h04
`define MSI_REG_EN      8'h08
`define MSI_REG_STATUS  8'h0C
// ID word for irq i at MSI_REG_ID0 + 4*i
`define MSI_REG_ID0     8'h10

`endif

//--- hdl/msi_pkg.sv
// Shared bus and config types; ID word layout assumes MSI_DEVID_W + MSI_EVTID_W == 32
`include "msi_macros.svh"

package msi_pkg;

  // ------------------------------
  // AXI response codes
  // ------------------------------
  typedef enum logic [1:0] {
    AXI_OKAY   = 2'b00,
    AXI_EXOKAY = 2'b01,
    AXI_SLVERR = 2'b10,
    AXI_DECERR = 2'b11
  } axi_resp_e;

  // ------------------------------
  // APB channels
  // ------------------------------
  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`MSI_APB_AW-1:0] paddr;
    logic [31:0]            pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // ------------------------------
  // AXI4-Lite write channels
  // ------------------------------
  // Initiator side, no read channels
  typedef struct packed {
    logic [`MSI_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic [`MSI_DATA_W-1:0] wdata;
    logic [`MSI_STRB_W-1:0] wstrb;
    logic                   wvalid;
    logic                   bready;
  } axil_wr_req_t;

  // Target side
  typedef struct packed {
    logic      awready;
    logic      wready;
    axi_resp_e bresp;
    logic      bvalid;
  } axil_wr_rsp_t;

  // ------------------------------
  // Configuration
  // ------------------------------
  // Field view of one ID register, device ID in the upper half
  typedef struct packed {
    logic [`MSI_DEVID_W-1:0] device_id;
    logic [`MSI_EVTID_W-1:0] event_id;
  } msi_ids_t;

  // Same word seen raw by APB and as fields by the generator
  typedef union packed {
    logic [31:0] raw;
    msi_ids_t    ids;
  } msi_id_word_u;

  typedef struct packed {
    logic [`MSI_NUM_IRQ-1:0]       en;
    logic                          throttle_en;
    logic [`MSI_THR_W-1:0]         thr;
    msi_id_word_u [`MSI_NUM_IRQ-1:0] id;
  } msi_cfg_t;

endpackage

//--- hdl/msi_rr_arbiter.sv
// Round-robin over MSI_NUM_IRQ requesters; a grant shown without accept stays locked until accepted
`timescale 1ns/10ps
`include "msi_macros.svh"

module msi_rr_arbiter (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`MSI_NUM_IRQ-1:0] req,
  input  logic                    accept,
  output logic [`MSI_NUM_IRQ-1:0] grant,
  output logic                    grant_valid
);

  localparam int N     = `MSI_NUM_IRQ;
  localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

  // Last winner, starts at N-1 so line 0 wins first
  logic [IDX_W-1:0] last_q;
  logic             lock_q;
  logic [N-1:0]     grant_q;
  logic [N-1:0]     pick;
  logic             pick_found;
  logic             held_ok;
  logic [IDX_W-1:0] grant_idx;

  // ------------------------------
  // Next requester after last winner
  // ------------------------------
  always_comb begin : rr_pick
    int idx;
    pick       = '0;
    pick_found = 1'b0;
    for (int off = 1; off <= N; off++) begin
      idx = (int'(last_q) + off) % N;
      if (!pick_found && req[idx]) begin
        pick[idx]  = 1'b1;
        pick_found = 1'b1;
      end
    end
  end

  // Locked choice stands only while its line still requests
  assign held_ok     = lock_q && |(grant_q & req);
  assign grant       = held_ok ? grant_q : pick;
  assign grant_valid = held_ok || pick_found;

  // One-hot to index for the pointer update
  always_comb begin
    grant_idx = '0;
    for (int i = 0; i < N; i++) begin
      if (grant[i]) grant_idx = IDX_W'(i);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_q  <= IDX_W'(N - 1);
      lock_q  <= 1'b0;
      grant_q <= '0;
    end else if (accept) begin
      // Winner served, move past it and unlock
      last_q <= grant_idx;
      lock_q <= 1'b0;
    end else begin
      lock_q <= grant_valid;
      // Held grant, qualified by lock_q
      if (grant_valid) grant_q <= grant;
    end
  end

endmodule

//--- hdl/msi_axil_gen.sv
// Level irq inputs only; one write in flight, bready held high and only the latest bresp is kept
`timescale 1ns/10ps
`include "msi_macros.svh"

module msi_axil_gen (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`MSI_NUM_IRQ-1:0] irq,
  input  msi_pkg::msi_cfg_t       cfg,
  output msi_pkg::axil_wr_req_t   axil_req,
  input  msi_pkg::axil_wr_rsp_t   axil_rsp,
  output logic                    error
);

  import msi_pkg::*;

  localparam int N        = `MSI_NUM_IRQ;
  // Low two address bits are always zero
  localparam int ADDR_PAD = `MSI_ADDR_W - `MSI_DEVID_W - 2;
  localparam int DATA_PAD = `MSI_DATA_W - `MSI_EVTID_W;
  localparam int STRB_PAD = `MSI_STRB_W - `MSI_EVT_STRB_W;

  logic [N-1:0]           irq_q;
  logic [N-1:0]           irq_d;
  logic [N-1:0]           irq_rise;
  logic [N-1:0]           pending_q;
  logic [N-1:0]           pending_next;
  logic [N-1:0]           grant;
  logic                   grant_valid;
  logic [N-1:0]           inflight;
  logic [N-1:0]           acc_mask;
  logic [`MSI_THR_W-1:0]  thr_cnt_q;
  logic                   clear_to_send;
  logic                   msg_valid;
  logic                   accept;
  msi_ids_t               ids_sel;

  // ------------------------------
  // Edge capture
  // ------------------------------
  // Sample stage then delay stage, rise seen one edge after sampling
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_q <= '0;
      irq_d <= '0;
    end else begin
      irq_q <= irq;
      irq_d <= irq_q;
    end
  end

  assign irq_rise = irq_q & ~irq_d;

  // ------------------------------
  // Pending tracking
  // ------------------------------
  // Presented line keeps its bit even if disabled meanwhile
  assign inflight = grant & {N{msg_valid}};
  assign acc_mask = grant & {N{accept}};
  // New rise on the accepted line in the same cycle is kept
  assign pending_next = (((pending_q & ~acc_mask) | irq_rise) & cfg.en)
                      | (inflight & ~acc_mask);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) pending_q <= '0;
    else        pending_q <= pending_next;
  end

  msi_rr_arbiter u_arb (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (pending_q),
    .accept      (accept),
    .grant       (grant),
    .grant_valid (grant_valid)
  );

  // ------------------------------
  // Throttle
  // ------------------------------
  // Reload while idle or on acceptance, count down while a request waits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      thr_cnt_q <= '0;
    end else if (!grant_valid || accept) begin
      thr_cnt_q <= cfg.thr;
    end else if (thr_cnt_q != '0) begin
      thr_cnt_q <= thr_cnt_q - `MSI_THR_W'(1);
    end
  end

  // Counter parks at zero until accept so valid cannot drop
  assign clear_to_send = !cfg.throttle_en || (thr_cnt_q == '0);
  assign msg_valid     = grant_valid && clear_to_send;
  assign accept        = msg_valid && axil_rsp.awready && axil_rsp.wready;

  // ------------------------------
  // Message format
  // ------------------------------
  // One-hot mux through the field view
  always_comb begin
    ids_sel = '0;
    for (int i = 0; i < N; i++) begin
      if (grant[i]) ids_sel = cfg.id[i].ids;
    end
  end

  assign axil_req.awaddr  = {{ADDR_PAD{1'b0}}, ids_sel.device_id, 2'b00};
  assign axil_req.awvalid = msg_valid;
  assign axil_req.wdata   = {{DATA_PAD{1'b0}}, ids_sel.event_id};
  assign axil_req.wstrb   = {{STRB_PAD{1'b0}}, {`MSI_EVT_STRB_W{1'b1}}};
  assign axil_req.wvalid  = msg_valid;
  // Response channel never stalls
  assign axil_req.bready  = 1'b1;

  // ------------------------------
  // Error from write response
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error <= 1'b0;
    end else if (axil_rsp.bvalid && axil_req.bready) begin
      error <= (axil_rsp.bresp != AXI_OKAY);
    end
  end

endmodule

//--- hdl/msi_apb_regs.sv
// Zero-wait APB slave, word offsets only; unmapped offsets raise pslverr, read 0 and ignore writes
`timescale 1ns/10ps
`include "msi_macros.svh"

module msi_apb_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  msi_pkg::apb_req_t  apb_req,
  output msi_pkg::apb_rsp_t  apb_rsp,
  output msi_pkg::msi_cfg_t  cfg,
  input  logic               error
);

  import msi_pkg::*;

  localparam int N = `MSI_NUM_IRQ;

  logic                  access;
  logic                  wr_en;
  logic                  hit_ctrl;
  logic                  hit_thr;
  logic                  hit_en;
  logic                  hit_status;
  logic [N-1:0]          hit_id;
  logic                  mapped;
  logic [31:0]           rd_data;

  // Register state
  logic                  throttle_en_q;
  logic [`MSI_THR_W-1:0] thr_q;
  logic [N-1:0]          en_q;
  msi_id_word_u [N-1:0]  id_q;

  // ------------------------------
  // Address decode
  // ------------------------------
  assign access = apb_req.psel && apb_req.penable;

  assign hit_ctrl   = (apb_req.paddr == `MSI_REG_CTRL);
  assign hit_thr    = (apb_req.paddr == `MSI_REG_THR);
  assign hit_en     = (apb_req.paddr == `MSI_REG_EN);
  assign hit_status = (apb_req.paddr == `MSI_REG_STATUS);

  // One ID word every 4 bytes from ID0
  always_comb begin
    for (int i = 0; i < N; i++) begin
      hit_id[i] = (apb_req.paddr == `MSI_APB_AW'(`MSI_REG_ID0 + 4 * i));
    end
  end

  assign mapped = hit_ctrl || hit_thr || hit_en || hit_status || (|hit_id);
  // Write commits at the edge ending the access phase
  assign wr_en  = access && apb_req.pwrite && mapped;

  // ------------------------------
  // Write path
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      throttle_en_q <= 1'b0;
      thr_q         <= '0;
      en_q          <= '0;
      id_q          <= '0;
    end else if (wr_en) begin
      if (hit_ctrl) throttle_en_q <= apb_req.pwdata[0];
      if (hit_thr)  thr_q         <= apb_req.pwdata[`MSI_THR_W-1:0];
      if (hit_en)   en_q          <= apb_req.pwdata[N-1:0];
      // STATUS is read-only, write dropped
      for (int i = 0; i < N; i++) begin
        if (hit_id[i]) id_q[i].raw <= apb_req.pwdata;
      end
    end
  end

  // ------------------------------
  // Read path
  // ------------------------------
  always_comb begin
    rd_data = '0;
    if (hit_ctrl)   rd_data[0]              = throttle_en_q;
    if (hit_thr)    rd_data[`MSI_THR_W-1:0] = thr_q;
    if (hit_en)     rd_data[N-1:0]          = en_q;
    if (hit_status) rd_data[0]              = error;
    for (int i = 0; i < N; i++) begin
      if (hit_id[i]) rd_data = id_q[i].raw;
    end
  end

  assign apb_rsp.prdata  = rd_data;
  // No wait states
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access && !mapped;

  // ------------------------------
  // Config to generator
  // ------------------------------
  assign cfg.en          = en_q;
  assign cfg.throttle_en = throttle_en_q;
  assign cfg.thr         = thr_q;
  assign cfg.id          = id_q;

endmodule

//--- hdl/msi_top.sv
// MSI subsystem, APB config in and AXI4-Lite writes out; irq lines must be level and synchronous to clk
`timescale 1ns/10ps
`include "msi_macros.svh"

module msi_top (
  input  logic                    clk,
  input  logic                    rst_n,
  // APB slave
  input  msi_pkg::apb_req_t       apb_req,
  output msi_pkg::apb_rsp_t       apb_rsp,
  // Interrupt lines
  input  logic [`MSI_NUM_IRQ-1:0] irq,
  // AXI4-Lite write initiator
  output msi_pkg::axil_wr_req_t   axil_req,
  input  msi_pkg::axil_wr_rsp_t   axil_rsp,
  output logic                    error
);

  import msi_pkg::*;

  // Config from registers to generator
  msi_cfg_t cfg;

  msi_apb_regs u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .cfg     (cfg),
    .error   (error)
  );

  // Error also leaves the top for the interrupt controller side
  msi_axil_gen u_gen (
    .clk      (clk),
    .rst_n    (rst_n),
    .irq      (irq),
    .cfg      (cfg),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .error    (error)
  );

endmodule

//--- dv/msi_chk.sv
// AXI4-Lite write checks bound into msi_axil_gen; assumes a single write in flight at a time
`timescale 1ns/10ps

module msi_chk (
  input logic                  clk,
  input logic                  rst_n,
  input msi_pkg::axil_wr_req_t axil_req,
  input msi_pkg::axil_wr_rsp_t axil_rsp
);

  logic stalled;

  // Offered but no handshake this cycle
  assign stalled = axil_req.awvalid && !(axil_rsp.awready && axil_rsp.wready);

  // ------------------------------
  // Write channel rules
  // ------------------------------
  valid_pair: assert property (@(posedge clk) disable iff (!rst_n)
    axil_req.awvalid == axil_req.wvalid)
    else $error("awvalid and wvalid differ");

  valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    stalled |=> axil_req.awvalid && axil_req.wvalid)
    else $error("write valid dropped before handshake");

  payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
    stalled |=> $stable(axil_req.awaddr) && $stable(axil_req.wdata)
                && $stable(axil_req.wstrb))
    else $error("write payload changed while stalled");

  // Nothing offered while reset is applied
  reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !axil_req.awvalid && !axil_req.wvalid)
    else $error("write valid high during reset");

endmodule

bind msi_axil_gen msi_chk u_chk (
  .clk      (clk),
  .rst_n    (rst_n),
  .axil_req (axil_req),
  .axil_rsp (axil_rsp)
);

//--- dv/msi_tb_tests.svh
// Directed tests for msi_tb, included in its body; tests run in order and leave irq low and EN zero

// ------------------------------
// Expected message model
// ------------------------------
// Device ID in the upper half of the ID word lands at byte address device_id * 4
function automatic logic [`MSI_ADDR_W-1:0] exp_awaddr(input logic [31:0] id_word);
  logic [`MSI_ADDR_W-1:0] dev;
  dev = `MSI_ADDR_W'(id_word[31:16]);
  return dev << 2;
endfunction

function automatic logic [`MSI_DATA_W-1:0] exp_wdata(input logic [31:0] id_word);
  return `MSI_DATA_W'(id_word[15:0]);
endfunction

// Only the two event ID bytes are written
function automatic logic [`MSI_STRB_W-1:0] exp_wstrb();
  return `MSI_STRB_W'(2'b11);
endfunction

task automatic check_msg(input string name, input int idx, input logic [31:0] id_word);
  // Missing writes were already reported by wait_msgs
  if (idx < msg_q.size()) begin
    check_addr(name, exp_awaddr(id_word), msg_q[idx]);
    check_wdata(name, exp_wdata(id_word), exp_wstrb(), msg_q[idx]);
  end
endtask

// ------------------------------
// Tests
// ------------------------------
task automatic test_regs();
  apb_rsp_t rsp;
  for (int i = 0; i < N; i++) begin
    id_words[i] = $random(seed);
    apb_write(`MSI_APB_AW'(`MSI_REG_ID0 + 4 * i), id_words[i]);
  end
  apb_write(`MSI_REG_EN, 32'h0000_000A);
  apb_write(`MSI_REG_CTRL, 32'h0000_0001);
  apb_write(`MSI_REG_THR, 32'h0000_5A3C);
  for (int i = 0; i < N; i++) begin
    apb_read(`MSI_APB_AW'(`MSI_REG_ID0 + 4 * i), rsp);
    check_apb($sformatf("regs ID%0d", i), id_words[i], 1'b0, rsp);
  end
  apb_read(`MSI_REG_EN, rsp);
  check_apb("regs EN", 32'h0000_000A, 1'b0, rsp);
  apb_read(`MSI_REG_CTRL, rsp);
  check_apb("regs CTRL", 32'h0000_0001, 1'b0, rsp);
  apb_read(`MSI_REG_THR, rsp);
  check_apb("regs THR", 32'h0000_5A3C, 1'b0, rsp);
  // Unmapped offset past the last ID word
  apb_read(8'h40, rsp);
  check_apb("regs unmapped", 32'h0, 1'b1, rsp);
  apb_write(`MSI_REG_EN, 32'h0);
  apb_write(`MSI_REG_CTRL, 32'h0);
  apb_write(`MSI_REG_THR, 32'h0);
  finish_test("register access");
endtask

task automatic test_format();
  clear_log();
  stall_cycles = 0;
  apb_write(`MSI_REG_EN, 32'h4);
  irq[2] = 1'b1;
  wait_msgs("format first", 1, 20);
  check_msg("format first", 0, id_words[2]);
  // Level held high sends nothing more
  idle(20);
  check_count("format held level", 1);
  irq[2] = 1'b0;
  idle(3);
  irq[2] = 1'b1;
  wait_msgs("format second", 2, 20);
  check_msg("format second", 1, id_words[2]);
  irq[2] = 1'b0;
  apb_write(`MSI_REG_EN, 32'h0);
  finish_test("message format");
endtask

task automatic test_enable();
  clear_log();
  irq[1] = 1'b1;
  idle(3);
  irq[1] = 1'b0;
  idle(20);
  check_count("enable disabled edge", 0);
  // Edge seen while disabled is not remembered
  apb_write(`MSI_REG_EN, 32'h2);
  idle(20);
  check_count("enable after enabling", 0);
  irq[1] = 1'b1;
  wait_msgs("enable new edge", 1, 20);
  check_msg("enable new edge", 0, id_words[1]);
  irq[1] = 1'b0;
  apb_write(`MSI_REG_EN, 32'h0);
  finish_test("enable mask");
endtask

task automatic test_round_robin();
  // Pointer back to its reset state, so line 0 wins first
  apply_reset();
  for (int i = 0; i < N; i++) begin
    apb_write(`MSI_APB_AW'(`MSI_REG_ID0 + 4 * i), id_words[i]);
  end
  apb_write(`MSI_REG_EN, 32'hF);
  clear_log();
  stall_cycles = 3;
  irq = '1;
  wait_msgs("rr", N, 80);
  for (int i = 0; i < N; i++) begin
    check_msg($sformatf("rr order %0d", i), i, id_words[i]);
  end
  stall_cycles = 0;
  irq = '0;
  idle(5);
  check_count("rr total", N);
  apb_write(`MSI_REG_EN, 32'h0);
  finish_test("round-robin with back-pressure");
endtask

task automatic test_throttle();
  int thr;
  int gap;
  thr = 6;
  apb_write(`MSI_REG_THR, 32'(thr));
  apb_write(`MSI_REG_CTRL, 32'h1);
  apb_write(`MSI_REG_EN, 32'hF);
  clear_log();
  irq = '1;
  wait_msgs("throttle", N, 100);
  for (int i = 1; i < msg_cyc_q.size(); i++) begin
    gap = msg_cyc_q[i] - msg_cyc_q[i-1];
    if (gap < thr) begin
      $display("MISMATCH throttle gap %0d: expected at least %0d cycles, actual %0d cycles",
               i, thr, gap);
      err_cnt++;
    end
  end
  irq = '0;
  apb_write(`MSI_REG_CTRL, 32'h0);
  apb_write(`MSI_REG_THR, 32'h0);
  apb_write(`MSI_REG_EN, 32'h0);
  finish_test("throttle spacing");
endtask

task automatic test_error();
  apb_rsp_t rsp;
  resp_code = AXI_SLVERR;
  apb_write(`MSI_REG_EN, 32'h1);
  clear_log();
  irq[0] = 1'b1;
  wait_msgs("error set", 1, 20);
  wait_error(1'b1, 10);
  check_error("error set", 1'b1, error);
  apb_read(`MSI_REG_STATUS, rsp);
  check_apb("error STATUS set", 32'h1, 1'b0, rsp);
  // Next response is OKAY and clears the flag
  resp_code = AXI_OKAY;
  irq[0] = 1'b0;
  idle(2);
  irq[0] = 1'b1;
  wait_msgs("error clear", 2, 20);
  wait_error(1'b0, 10);
  check_error("error clear", 1'b0, error);
  apb_read(`MSI_REG_STATUS, rsp);
  check_apb("error STATUS clear", 32'h0, 1'b0, rsp);
  irq[0] = 1'b0;
  apb_write(`MSI_REG_EN, 32'h0);
  finish_test("write response error");
endtask

//--- dv/msi_tb.sv
// Directed testbench for msi_top; the AXI4-Lite target stalls by a set count and logs each write
`timescale 1ns/10ps
`include "msi_macros.svh"

module msi_tb;

  import msi_pkg::*;

  localparam int N          = `MSI_NUM_IRQ;
  localparam int CLK_PERIOD = 40;
  // Cycle budget per test in run order: reset, regs, format, enable, rr, throttle, error
  localparam int BUDGET_CYC = 20 + 100 + 120 + 120 + 200 + 150 + 120;

  logic         clk;
  logic         rst_n;
  apb_req_t     apb_req;
  apb_rsp_t     apb_rsp;
  logic [N-1:0] irq;
  axil_wr_req_t axil_req;
  axil_wr_rsp_t axil_rsp;
  logic         error;

  int           cyc;
  int           err_cnt;
  int           tgt_err_cnt;
  int           test_err_base;
  int           tests_run;
  int           tests_failed;
  integer       seed;
  logic [31:0]  id_words [N];

  // Target knobs and write log
  int           stall_cycles;
  axi_resp_e    resp_code;
  axil_wr_req_t msg_q [$];
  int           msg_cyc_q [$];

  msi_top dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .irq      (irq),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .error    (error)
  );

  initial begin : clock_gen
    clk = 1'b0;
    cyc = 0;
    forever begin
      #(CLK_PERIOD / 2) clk = 1'b1;
      cyc++;
      #(CLK_PERIOD / 2) clk = 1'b0;
    end
  end

  initial begin : watchdog
    #(BUDGET_CYC * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, tests did not finish", BUDGET_CYC);
    $display("Test failed");
    $finish;
  end

  // ------------------------------
  // AXI4-Lite target model
  // ------------------------------
  initial begin : axil_target
    axil_wr_req_t held;
    logic         stalled;
    logic         b_next;
    int           wait_cnt;
    held             = '0;
    stalled          = 1'b0;
    b_next           = 1'b0;
    wait_cnt         = 0;
    axil_rsp.awready = 1'b0;
    axil_rsp.wready  = 1'b0;
    axil_rsp.bresp   = AXI_OKAY;
    axil_rsp.bvalid  = 1'b0;
    forever begin
      @(negedge clk);
      // Response one cycle after the handshake
      axil_rsp.bvalid  = b_next;
      axil_rsp.bresp   = b_next ? resp_code : AXI_OKAY;
      b_next           = 1'b0;
      axil_rsp.awready = 1'b0;
      axil_rsp.wready  = 1'b0;
      if (rst_n && axil_req.bready !== 1'b1) begin
        $display("Response channel not ready (bready low) at cycle %0d", cyc);
        tgt_err_cnt++;
      end
      if (rst_n && (axil_req.awvalid != axil_req.wvalid)) begin
        $display("awvalid and wvalid differ at cycle %0d", cyc);
        tgt_err_cnt++;
      end
      if (stalled && !axil_req.awvalid) begin
        $display("Write valid dropped before acceptance at cycle %0d", cyc);
        tgt_err_cnt++;
      end
      if (stalled && axil_req.awvalid && (axil_req.awaddr != held.awaddr ||
          axil_req.wdata != held.wdata || axil_req.wstrb != held.wstrb)) begin
        $display("Write payload changed during a stall at cycle %0d", cyc);
        tgt_err_cnt++;
      end
      stalled = 1'b0;
      if (axil_req.awvalid) begin
        if (wait_cnt >= stall_cycles) begin
          // Handshake lands on the next rising edge
          axil_rsp.awready = 1'b1;
          axil_rsp.wready  = 1'b1;
          msg_q.push_back(axil_req);
          msg_cyc_q.push_back(cyc);
          b_next   = 1'b1;
          wait_cnt = 0;
        end else begin
          held     = axil_req;
          stalled  = 1'b1;
          wait_cnt++;
        end
      end
    end
  end

  // ------------------------------
  // Bus and sequencing helpers
  // ------------------------------
  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic apb_write(input logic [`MSI_APB_AW-1:0] addr, input logic [31:0] data);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic apb_read(input logic [`MSI_APB_AW-1:0] addr, output apb_rsp_t rsp);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    apb_req.pwdata  = '0;
    @(negedge clk);
    apb_req.penable = 1'b1;
    // Mid low phase, clear of both edges
    #(CLK_PERIOD / 4);
    rsp = apb_rsp;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic clear_log();
    msg_q.delete();
    msg_cyc_q.delete();
  endtask

  task automatic wait_msgs(input string name, input int count, input int max_cyc);
    int n;
    n = 0;
    while (msg_q.size() < count && n < max_cyc) begin
      @(negedge clk);
      n++;
    end
    if (msg_q.size() < count) begin
      $display("%s: no write %0d within %0d cycles", name, count, max_cyc);
      err_cnt++;
    end
  endtask

  task automatic wait_error(input logic val, input int max_cyc);
    int n;
    n = 0;
    while (error !== val && n < max_cyc) begin
      @(negedge clk);
      n++;
    end
  endtask

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_apb(input string name, input logic [31:0] exp_data,
                           input logic exp_err, input apb_rsp_t act);
    if (act.prdata !== exp_data || act.pslverr !== exp_err) begin
      $display("MISMATCH %s: expected prdata=%08h pslverr=%0b, actual prdata=%08h pslverr=%0b",
               name, exp_data, exp_err, act.prdata, act.pslverr);
      err_cnt++;
    end
    // No wait states on this slave
    if (act.pready !== 1'b1) begin
      $display("MISMATCH %s: expected pready=1, actual pready=%0b", name, act.pready);
      err_cnt++;
    end
  endtask

  task automatic check_addr(input string name, input logic [`MSI_ADDR_W-1:0] exp_addr,
                            input axil_wr_req_t act);
    if (act.awaddr !== exp_addr) begin
      $display("MISMATCH %s: expected awaddr=%h, actual awaddr=%h", name, exp_addr, act.awaddr);
      err_cnt++;
    end
  endtask

  task automatic check_wdata(input string name, input logic [`MSI_DATA_W-1:0] exp_data,
                             input logic [`MSI_STRB_W-1:0] exp_strb, input axil_wr_req_t act);
    if (act.wdata !== exp_data || act.wstrb !== exp_strb) begin
      $display("MISMATCH %s: expected wdata=%h wstrb=%b, actual wdata=%h wstrb=%b",
               name, exp_data, exp_strb, act.wdata, act.wstrb);
      err_cnt++;
    end
  endtask

  task automatic check_error(input string name, input logic exp_err, input logic act);
    if (act !== exp_err) begin
      $display("MISMATCH %s: expected error=%0b, actual error=%0b", name, exp_err, act);
      err_cnt++;
    end
  endtask

  task automatic check_count(input string name, input int exp_cnt);
    if (msg_q.size() != exp_cnt) begin
      $display("MISMATCH %s: expected %0d writes, actual %0d writes", name, exp_cnt, msg_q.size());
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = err_cnt + tgt_err_cnt - test_err_base;
    tests_run++;
    if (errs == 0) begin
      $display("PASS  %s", name);
    end else begin
      tests_failed++;
      $display("FAIL  %s with %0d errors", name, errs);
    end
    test_err_base = err_cnt + tgt_err_cnt;
  endtask

  `include "msi_tb_tests.svh"

  initial begin : main
    apb_req       = '0;
    irq           = '0;
    rst_n         = 1'b0;
    seed          = 32'h9199_e202;
    err_cnt       = 0;
    tgt_err_cnt   = 0;
    test_err_base = 0;
    tests_run     = 0;
    tests_failed  = 0;
    stall_cycles  = 0;
    resp_code     = AXI_OKAY;
    apply_reset();
    test_regs();
    test_format();
    test_enable();
    test_round_robin();
    test_throttle();
    test_error();
    $display("Summary: %0d tests, %0d failed, %0d errors",
             tests_run, tests_failed, err_cnt + tgt_err_cnt);
    if (tests_failed == 0 && err_cnt + tgt_err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+hdl
+incdir+dv
hdl/msi_pkg.sv
hdl/msi_rr_arbiter.sv
hdl/msi_axil_gen.sv
hdl/msi_apb_regs.sv
hdl/msi_top.sv
dv/msi_chk.sv
dv/msi_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the MSI generator testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module msi_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vmsi_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
  exit 0
fi
exit 1
